/* tb.f */
+incdir+include
rtl/ld_fixed_pkg.sv
rtl/ld_ctrl_pkg.sv
rtl/scratch_mem.sv
rtl/frac_divider.sv
rtl/ld_mac.sv
rtl/levinson_fsm.sv
rtl/levinson_top.sv
sim/levinson_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= levinson_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* include/ld_ref_model.svh */
`ifndef LD_REF_MODEL_SVH
`define LD_REF_MODEL_SVH

// Bit-exact model of the fixed-point recursion
// a_out and rc_out are indexed 1..order, entry 0 unused
function automatic void ld_ref_solve(
	input  int                 order,
	input  logic signed [31:0] r [16],
	output logic signed [15:0] a_out [16],
	output logic signed [15:0] rc_out [16],
	output bit                 unstable
);
	longint err;
	longint acc;
	longint mag;
	longint k;
	longint v;
	int a [16];
	int an [16];
	err = longint'(r[0]);
	unstable = 1'b0;
	for (int n = 0; n < 16; n++)
	begin
		a[n] = 0;
		an[n] = 0;
		a_out[n] = '0;
		rc_out[n] = '0;
	end
	for (int i = 1; i <= order; i++)
	begin
		acc = 0;
		for (int j = 1; j < i; j++)
			acc += longint'(a[j]) * longint'(r[i-j]);
		acc = (acc >>> 27) + longint'(r[i]);
		mag = (acc < 0) ? -acc : acc;
		// Reflection would reach magnitude one
		if (mag >= err)
		begin
			unstable = 1'b1;
			break;
		end
		k = (-acc * 32768) / err;
		for (int j = 1; j < i; j++)
			an[j] = int'(longint'(a[j]) + ((k * longint'(a[i-j])) >>> 15));
		an[i] = int'(k <<< 12);
		rc_out[i] = 16'(k);
		for (int j = 1; j <= i; j++)
			a[j] = an[j];
		err = err - ((err * (k * k)) >>> 30);
	end
	// Q27 to Q12 with saturation
	for (int j = 1; j <= order; j++)
	begin
		v = longint'(a[j]) >>> 15;
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		a_out[j] = 16'(v);
	end
endfunction

`endif

/* sim/levinson_tb.sv */
`timescale 1ns/1ps

module levinson_tb
	import ld_fixed_pkg::*;
();

	localparam int ORDER = 10;
	localparam int N_ITEMS = 2 * ORDER;
	// Samples behind each random autocorrelation
	localparam int SEQ_LEN = ORDER + 8;
	localparam int N_RANDOM = 6;
	localparam int WAIT_LIMIT = 4000;

	logic             clock;
	logic             rst_n;
	logic             load_valid;
	logic             load_ready;
	logic [IDX_W-1:0] load_index;
	logic [R_W-1:0]   load_data;
	logic             start;
	logic             busy;
	logic             done;
	logic             unstable;
	logic             res_valid;
	logic             res_ready;
	logic [OUT_W-1:0] res_data;
	logic             res_kind;
	logic [IDX_W-1:0] res_index;

	// Stream items of the last frame in arrival order
	logic [OUT_W-1:0] got_data [N_ITEMS];
	logic             got_kind [N_ITEMS];
	logic [IDX_W-1:0] got_index [N_ITEMS];
	logic             got_unstable;
	int               n_items;
	// Copy of a frame taken without back-pressure
	logic [OUT_W-1:0] base_data [N_ITEMS];
	logic             base_kind [N_ITEMS];
	logic [IDX_W-1:0] base_index [N_ITEMS];

	`include "ld_ref_model.svh"

	levinson_top #(.ORDER(ORDER)) uut (
		.clock(clock), .rst_n(rst_n),
		.load_valid(load_valid), .load_ready(load_ready),
		.load_index(load_index), .load_data(load_data),
		.start(start), .busy(busy), .done(done), .unstable(unstable),
		.res_valid(res_valid), .res_ready(res_ready), .res_data(res_data),
		.res_kind(res_kind), .res_index(res_index)
	);

	always #10 clock = ~clock;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	////////////////////
	// Protocol checks
	////////////////////

	// Stalled item holds
	a_stall_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		(res_valid && !res_ready) |=>
			(res_valid && $stable(res_data) && $stable(res_kind) && $stable(res_index))
	) else fail_now($sformatf("[ERROR] res_data %h res_kind %h res_index %h moved while stalled",
		res_data, res_kind, res_index));

	// No loads while solving
	a_load_closed: assert property (
		@(posedge clock) disable iff (!rst_n)
		busy |-> !load_ready
	) else fail_now($sformatf("[ERROR] load_ready %h while busy %h", load_ready, busy));

	a_done_pulse: assert property (
		@(posedge clock) disable iff (!rst_n)
		done |=> !done
	) else fail_now("done stayed high for more than one cycle");

	////////////////////
	// Stimulus
	////////////////////

	// Autocorrelation of colored noise with r[0] lifted by a noise floor
	function automatic void make_random_frame(output logic signed [R_W-1:0] r [16]);
		int x [SEQ_LEN];
		int prev;
		int pole;
		longint s;
		prev = 0;
		pole = int'($urandom_range(0, 6)) - 3;
		for (int n = 0; n < SEQ_LEN; n++)
		begin
			x[n] = int'($urandom_range(0, 2047)) - 1024 + (prev * pole) / 4;
			prev = x[n];
		end
		for (int lag = 0; lag < 16; lag++)
		begin
			s = 0;
			if (lag <= ORDER)
			begin
				for (int n = 0; n + lag < SEQ_LEN; n++)
					s += longint'(x[n]) * longint'(x[n + lag]);
			end
			r[lag] = R_W'(s);
		end
		r[0] = r[0] + (r[0] >>> 4) + 1;
	endfunction

	// r[0..ORDER] through the load port
	task automatic load_frame(input logic signed [R_W-1:0] r [16]);
		int guard;
		for (int n = 0; n <= ORDER; n++)
		begin
			guard = 0;
			while (!load_ready)
			begin
				@(negedge clock);
				guard++;
				if (guard > WAIT_LIMIT)
					fail_now("load port never became ready");
			end
			load_valid = 1'b1;
			load_index = IDX_W'(n);
			load_data = r[n];
			@(negedge clock);
		end
		load_valid = 1'b0;
	endtask

	task automatic run_frame(input logic signed [R_W-1:0] r [16], input bit random_ready);
		int guard;
		int busy_cycles;
		bit rdy;
		bit took;
		bit prev_took;
		bit seen_done;
		load_frame(r);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		assert (busy && !load_ready)
		else fail_now($sformatf("[ERROR] busy %h load_ready %h after start", busy, load_ready));
		n_items = 0;
		busy_cycles = 0;
		guard = 0;
		prev_took = 1'b0;
		seen_done = 1'b0;
		while (!seen_done)
		begin
			// Ready for the coming edge
			rdy = random_ready ? ($urandom_range(0, 2) != 0) : 1'b1;
			res_ready = rdy;
			// Stray start while solving
			start = busy && (busy_cycles == 3);
			if (busy)
				busy_cycles++;
			took = res_valid && rdy;
			if (took)
			begin
				assert (n_items < N_ITEMS)
				else fail_now("more result items than two per order");
				got_data[n_items] = res_data;
				got_kind[n_items] = res_kind;
				got_index[n_items] = res_index;
				n_items++;
			end
			if (done)
			begin
				// Done right after the last handshake
				assert (prev_took && n_items == N_ITEMS)
				else fail_now($sformatf("done came after %0d items", n_items));
				got_unstable = unstable;
				seen_done = 1'b1;
			end
			prev_took = took;
			@(negedge clock);
			guard++;
			if (guard > WAIT_LIMIT)
				fail_now("timeout waiting for done");
		end
		start = 1'b0;
		res_ready = 1'b0;
		// Nothing follows since one start gives one frame
		for (int n = 0; n < 3 * ORDER; n++)
		begin
			assert (!busy && !done && !res_valid && !unstable && load_ready)
			else fail_now("activity after done, a second frame may have started");
			@(negedge clock);
		end
	endtask

	////////////////////
	// Result checks
	////////////////////

	task automatic check_frame(input logic signed [R_W-1:0] r [16]);
		logic signed [OUT_W-1:0] exp_a [16];
		logic signed [OUT_W-1:0] exp_rc [16];
		bit exp_unstable;
		logic [OUT_W-1:0] exp_data;
		logic exp_kind;
		int idx;
		ld_ref_solve(ORDER, r, exp_a, exp_rc, exp_unstable);
		assert (got_unstable == exp_unstable)
		else fail_now($sformatf("[ERROR] unstable got %h expected %h", got_unstable, exp_unstable));
		for (int n = 0; n < N_ITEMS; n++)
		begin
			// a[1..ORDER] then rc[1..ORDER]
			exp_kind = (n >= ORDER);
			idx = exp_kind ? n - ORDER + 1 : n + 1;
			exp_data = exp_kind ? exp_rc[idx] : exp_a[idx];
			assert (got_kind[n] == exp_kind)
			else fail_now($sformatf("[ERROR] res_kind item %0d got %h expected %h",
				n, got_kind[n], exp_kind));
			assert (got_index[n] == IDX_W'(idx))
			else fail_now($sformatf("[ERROR] res_index item %0d got %h expected %h",
				n, got_index[n], IDX_W'(idx)));
			assert (got_data[n] == exp_data)
			else fail_now($sformatf("[ERROR] res_data item %0d got %h expected %h",
				n, got_data[n], exp_data));
		end
	endtask

	task automatic check_all_zero(input bit exp_unstable);
		assert (got_unstable == exp_unstable)
		else fail_now($sformatf("[ERROR] unstable got %h expected %h", got_unstable, exp_unstable));
		for (int n = 0; n < N_ITEMS; n++)
		begin
			assert (got_data[n] == '0)
			else fail_now($sformatf("[ERROR] res_data item %0d got %h expected %h",
				n, got_data[n], 16'h0000));
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		logic signed [R_W-1:0] r [16];
		void'($urandom(33436));
		clock = 1'b0;
		rst_n = 1'b0;
		load_valid = 1'b0;
		load_index = '0;
		load_data = '0;
		start = 1'b0;
		res_ready = 1'b0;
		got_unstable = 1'b0;
		n_items = 0;
		repeat (10) @(negedge clock);
		assert (!busy && !done && !res_valid && !unstable && load_ready && !uut.u_div.out_valid)
		else fail_now("outputs not at their reset values");
		rst_n = 1'b1;
		@(negedge clock);

		// Impulse
		for (int n = 0; n < 16; n++)
			r[n] = '0;
		r[0] = 32'sd1 <<< 20;
		run_frame(r, 1'b0);
		check_all_zero(1'b0);
		check_frame(r);

		// Random frames with every other one stalled
		for (int f = 0; f < N_RANDOM; f++)
		begin
			make_random_frame(r);
			run_frame(r, f[0]);
			check_frame(r);
		end

		// Reflection of one at order 1
		make_random_frame(r);
		r[1] = r[0];
		run_frame(r, 1'b0);
		check_all_zero(1'b1);
		check_frame(r);

		// Same frame plain and then stalled
		make_random_frame(r);
		run_frame(r, 1'b0);
		check_frame(r);
		for (int n = 0; n < N_ITEMS; n++)
		begin
			base_data[n] = got_data[n];
			base_kind[n] = got_kind[n];
			base_index[n] = got_index[n];
		end
		run_frame(r, 1'b1);
		for (int n = 0; n < N_ITEMS; n++)
		begin
			assert (got_data[n] == base_data[n])
			else fail_now($sformatf("[ERROR] res_data item %0d stalled %h plain %h",
				n, got_data[n], base_data[n]));
			assert (got_kind[n] == base_kind[n])
			else fail_now($sformatf("[ERROR] res_kind item %0d stalled %h plain %h",
				n, got_kind[n], base_kind[n]));
			assert (got_index[n] == base_index[n])
			else fail_now($sformatf("[ERROR] res_index item %0d stalled %h plain %h",
				n, got_index[n], base_index[n]));
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

/* rtl/levinson_top.sv */
`timescale 1ns/1ps

module levinson_top
	import ld_fixed_pkg::*;
	import ld_ctrl_pkg::*;
#(
	parameter int ORDER = 10
)
(
	input  logic             clock,
	input  logic             rst_n,
	input  logic             load_valid,
	output logic             load_ready,
	input  logic [IDX_W-1:0] load_index,
	input  logic [R_W-1:0]   load_data,
	input  logic             start,
	output logic             busy,
	output logic             done,
	output logic             unstable,
	output logic             res_valid,
	input  logic             res_ready,
	output logic [OUT_W-1:0] res_data,
	output logic             res_kind,
	output logic [IDX_W-1:0] res_index
);

	// Scratch memory port
	logic [MEM_AW-1:0] mem_addr;
	logic mem_wr_en;
	logic [R_W-1:0] mem_wr_data, mem_rd_data;
	// Multiplier
	mac_op_e mac_op;
	coef_t mac_a, mac_b;
	logic [SHIFT_W-1:0] mac_shift;
	acc_t mac_acc;
	// Divider
	logic div_in_valid, div_in_ready, div_negate, div_out_valid, div_out_ready;
	logic [R_W-1:0] div_dividend, div_divisor;
	logic signed [OUT_W-1:0] div_quotient;

	scratch_mem u_mem (
		.clock(clock), .rst_n(rst_n), .addr(mem_addr), .wr_en(mem_wr_en),
		.wr_data(mem_wr_data), .rd_data(mem_rd_data)
	);

	ld_mac u_mac (
		.clock(clock), .rst_n(rst_n), .op(mac_op), .opa(mac_a), .opb(mac_b),
		.shift(mac_shift), .acc(mac_acc)
	);

	frac_divider u_div (
		.clock(clock), .rst_n(rst_n), .in_valid(div_in_valid), .in_ready(div_in_ready),
		.dividend(div_dividend), .divisor(div_divisor), .negate(div_negate),
		.out_valid(div_out_valid), .out_ready(div_out_ready), .quotient(div_quotient)
	);

	levinson_fsm #(.ORDER(ORDER)) u_fsm (
		.clock(clock), .rst_n(rst_n),
		.load_valid(load_valid), .load_ready(load_ready),
		.load_index(load_index), .load_data(load_data),
		.start(start), .busy(busy), .done(done), .unstable(unstable),
		.mem_addr(mem_addr), .mem_wr_en(mem_wr_en),
		.mem_wr_data(mem_wr_data), .mem_rd_data(mem_rd_data),
		.mac_op(mac_op), .mac_a(mac_a), .mac_b(mac_b), .mac_shift(mac_shift), .mac_acc(mac_acc),
		.div_in_valid(div_in_valid), .div_in_ready(div_in_ready),
		.div_dividend(div_dividend), .div_divisor(div_divisor), .div_negate(div_negate),
		.div_out_valid(div_out_valid), .div_out_ready(div_out_ready),
		.div_quotient(div_quotient),
		.res_valid(res_valid), .res_ready(res_ready), .res_data(res_data),
		.res_kind(res_kind), .res_index(res_index)
	);

endmodule

/* rtl/levinson_fsm.sv */
`timescale 1ns/1ps

module levinson_fsm
	import ld_fixed_pkg::*;
	import ld_ctrl_pkg::*;
#(
	parameter int ORDER = 10
)
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    load_valid,
	output logic                    load_ready,
	input  logic [IDX_W-1:0]        load_index,
	input  logic [R_W-1:0]          load_data,
	input  logic                    start,
	output logic                    busy,
	output logic                    done,
	output logic                    unstable,
	output logic [MEM_AW-1:0]       mem_addr,
	output logic                    mem_wr_en,
	output logic [R_W-1:0]          mem_wr_data,
	input  logic [R_W-1:0]          mem_rd_data,
	output mac_op_e                 mac_op,
	output coef_t                   mac_a,
	output coef_t                   mac_b,
	output logic [SHIFT_W-1:0]      mac_shift,
	input  acc_t                    mac_acc,
	output logic                    div_in_valid,
	input  logic                    div_in_ready,
	output logic [R_W-1:0]          div_dividend,
	output logic [R_W-1:0]          div_divisor,
	output logic                    div_negate,
	input  logic                    div_out_valid,
	output logic                    div_out_ready,
	input  logic signed [OUT_W-1:0] div_quotient,
	output logic                    res_valid,
	input  logic                    res_ready,
	output logic [OUT_W-1:0]        res_data,
	output logic                    res_kind,
	output logic [IDX_W-1:0]        res_index
);

	localparam logic [IDX_W-1:0] ORD = IDX_W'(ORDER);
	localparam logic [IDX_W:0] LAST = (IDX_W+1)'(2 * ORDER - 1);

	ld_state_e state;
	logic [2:0] ph;
	logic [IDX_W-1:0] i, j, n_valid;
	logic [IDX_W:0] cnt;
	logic bank_sel;
	coef_t err, a_val, k_ext, shifted;
	acc_t sum, sum_mag;
	logic signed [OUT_W-1:0] k;
	logic [OUT_W-1:0] res_data_q, conv;
	region_e src, dst;
	logic stable;

	// Source bank alternates every order
	assign src = bank_sel ? A_PONG : A_PING;
	assign dst = bank_sel ? A_PING : A_PONG;
	assign k_ext = coef_t'(k);
	assign sum_mag = sum[ACC_W-1] ? -sum : sum;
	assign stable = sum_mag < acc_t'(err);

	assign load_ready = (state == IDLE);
	assign busy = (state != IDLE);
	assign done = (state == FINISH);
	assign res_valid = (state == STREAM) && (ph == 3'd2);
	assign res_data = res_data_q;
	assign res_kind = (cnt >= (IDX_W+1)'(ORDER));
	assign res_index = res_kind ? IDX_W'(cnt - (IDX_W+1)'(ORDER) + 1'b1) : IDX_W'(cnt + 1'b1);

	assign div_dividend = sum_mag[R_W-1:0];
	assign div_divisor = err;
	// k has the opposite sign of the sum
	assign div_negate = !sum[ACC_W-1] && (sum != '0);

	////////////////////
	// Output format
	////////////////////

	assign shifted = $signed(mem_rd_data) >>> (Q_A - Q_OUT);
	always_comb
	begin
		if (res_index > n_valid)
			conv = '0;
		else if (res_kind)
			conv = mem_rd_data[OUT_W-1:0];
		else if (shifted > coef_t'(32767))
			conv = 16'h7fff;
		else if (shifted < -coef_t'(32768))
			conv = 16'h8000;
		else
			conv = shifted[OUT_W-1:0];
	end

	////////////////////
	// Memory, MAC, divider drive
	////////////////////

	always_comb
	begin
		mem_addr = '0;
		mem_wr_en = 1'b0;
		mem_wr_data = '0;
		// Hold by default
		mac_op = ACCUM;
		mac_a = '0;
		mac_b = '0;
		mac_shift = '0;
		div_in_valid = 1'b0;
		div_out_ready = 1'b0;
		case (state)
			IDLE:
			begin
				// Load port owns the memory while idle
				mem_addr = {R_REGION, load_index};
				mem_wr_en = load_valid;
				mem_wr_data = load_data;
			end
			SUM:
			begin
				case (ph)
					3'd0: mem_addr = (j < i) ? {src, j} : {R_REGION, i};
					3'd1: mem_addr = {R_REGION, IDX_W'(i - j)};
					3'd2:
					begin
						mac_a = a_val;
						mac_b = mem_rd_data;
					end
					3'd6: mem_addr = {R_REGION, {IDX_W{1'b0}}};
					3'd7: mac_op = CLEAR;
					default: mac_op = ACCUM;
				endcase
			end
			CHECK: div_in_valid = stable;
			DIVIDE: div_out_ready = 1'b1;
			UPDATE:
			begin
				case (ph)
					3'd0: mem_addr = {src, IDX_W'(i - j)};
					3'd1:
					begin
						// k times mirrored coefficient, back to Q27
						mac_op = PRODUCT;
						mac_a = k_ext;
						mac_b = mem_rd_data;
						mac_shift = SHIFT_W'(Q_K);
						mem_addr = {src, j};
					end
					3'd2:
					begin
						mem_addr = {dst, j};
						mem_wr_en = 1'b1;
						mem_wr_data = mem_rd_data + mac_acc[R_W-1:0];
					end
					3'd3:
					begin
						mem_addr = {dst, i};
						mem_wr_en = 1'b1;
						mem_wr_data = k_ext <<< (Q_A - Q_K);
						mac_op = PRODUCT;
						mac_a = k_ext;
						mac_b = k_ext;
					end
					3'd4:
					begin
						mem_addr = {RC_REGION, i};
						mem_wr_en = 1'b1;
						mem_wr_data = k_ext;
						// err times k squared, Q30 dropped
						mac_op = PRODUCT;
						mac_a = err;
						mac_b = mac_acc[R_W-1:0];
						mac_shift = SHIFT_W'(2 * Q_K);
					end
					default: mac_op = ACCUM;
				endcase
			end
			NEXT: mac_op = CLEAR;
			STREAM: mem_addr = res_kind ? {RC_REGION, res_index} : {src, res_index};
			default: mac_op = ACCUM;
		endcase
	end

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			ph <= '0;
			i <= '0;
			j <= '0;
			n_valid <= '0;
			cnt <= '0;
			bank_sel <= 1'b0;
			unstable <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= SUM;
						ph <= 3'd6;
						i <= IDX_W'(1);
						j <= IDX_W'(1);
						bank_sel <= 1'b0;
					end
				end
				SUM:
				begin
					case (ph)
						3'd0: ph <= (j < i) ? 3'd1 : 3'd3;
						3'd2:
						begin
							j <= j + 1'b1;
							ph <= 3'd0;
						end
						3'd3: state <= CHECK;
						3'd7: ph <= 3'd0;
						default: ph <= ph + 3'd1;
					endcase
				end
				CHECK:
				begin
					if (!stable)
					begin
						// Keep the bank of the last good order
						unstable <= 1'b1;
						n_valid <= i - 1'b1;
						cnt <= '0;
						ph <= '0;
						state <= STREAM;
					end
					else if (div_in_ready)
					begin
						state <= DIVIDE;
					end
				end
				DIVIDE:
				begin
					if (div_out_valid)
					begin
						j <= IDX_W'(1);
						ph <= '0;
						state <= UPDATE;
					end
				end
				UPDATE:
				begin
					case (ph)
						3'd0: ph <= (j < i) ? 3'd1 : 3'd3;
						3'd2:
						begin
							j <= j + 1'b1;
							ph <= 3'd0;
						end
						3'd5: state <= NEXT;
						default: ph <= ph + 3'd1;
					endcase
				end
				NEXT:
				begin
					bank_sel <= !bank_sel;
					ph <= '0;
					j <= IDX_W'(1);
					if (i == ORD)
					begin
						n_valid <= i;
						cnt <= '0;
						state <= STREAM;
					end
					else
					begin
						i <= i + 1'b1;
						state <= SUM;
					end
				end
				STREAM:
				begin
					if (ph != 3'd2)
						ph <= ph + 3'd1;
					else if (res_ready)
					begin
						ph <= '0;
						if (cnt == LAST)
							state <= FINISH;
						else
							cnt <= cnt + 1'b1;
					end
				end
				default:
				begin
					// Pulse done, drop the flag next cycle
					unstable <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clock)
	begin
		if (state == SUM && ph == 3'd1)
			a_val <= mem_rd_data;
		if (state == SUM && ph == 3'd3)
			sum <= (mac_acc >>> Q_A) + acc_t'($signed(mem_rd_data));
		if (state == SUM && ph == 3'd7)
			err <= mem_rd_data;
		if (state == UPDATE && ph == 3'd5)
			err <= err - mac_acc[R_W-1:0];
		if (state == DIVIDE && div_out_valid)
			k <= div_quotient;
		if (state == STREAM && ph == 3'd1)
			res_data_q <= conv;
	end

	// Stream item holds under back-pressure
	a_res_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		(res_valid && !res_ready) |=>
			(res_valid && $stable(res_data) && $stable(res_kind) && $stable(res_index))
	) else $error("[ERROR] result changed under back-pressure, data %h", res_data);

endmodule

/* rtl/ld_mac.sv */
`timescale 1ns/1ps

module ld_mac
	import ld_fixed_pkg::*;
	import ld_ctrl_pkg::*;
(
	input  logic               clock,
	input  logic               rst_n,
	input  mac_op_e            op,
	input  coef_t              opa,
	input  coef_t              opb,
	input  logic [SHIFT_W-1:0] shift,
	output acc_t               acc
);

	acc_t prod;

	// Full 64-bit signed product
	assign prod = acc_t'(opa) * acc_t'(opb);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			acc <= '0;
		end
		else
		begin
			case (op)
				CLEAR:
				begin
					acc <= '0;
				end
				ACCUM:
				begin
					acc <= acc + prod;
				end
				PRODUCT:
				begin
					// Arithmetic shift floors
					acc <= prod >>> shift;
				end
				default:
				begin
					acc <= acc;
				end
			endcase
		end
	end

endmodule

/* rtl/frac_divider.sv */
`timescale 1ns/1ps

module frac_divider
	import ld_fixed_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  logic [R_W-1:0]          dividend,
	input  logic [R_W-1:0]          divisor,
	input  logic                    negate,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic signed [OUT_W-1:0] quotient
);

	logic                 busy;
	logic [4:0]           cnt;
	// Partial remainder, always below divisor
	logic [R_W:0]         rem;
	// Low dividend bit then the Q15 zeros, shifted in MSB first
	logic [DIV_ITERS-1:0] nbits;
	logic [OUT_W-1:0]     q;
	logic [R_W-1:0]       dvs;
	logic                 neg;
	logic [R_W:0]         trial;

	assign in_ready = !busy && !out_valid;
	assign trial = {rem[R_W-1:0], nbits[DIV_ITERS-1]};
	// Sign goes on last
	assign quotient = neg ? -$signed(q) : $signed(q);

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			cnt <= '0;
		end
		else if (in_valid && in_ready)
		begin
			busy <= 1'b1;
			cnt <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 5'd1;
			// Sixteenth bit done
			if (cnt == 5'(DIV_ITERS - 1))
			begin
				busy <= 1'b0;
				out_valid <= 1'b1;
			end
		end
		else if (out_valid && out_ready)
		begin
			out_valid <= 1'b0;
		end
	end

	////////////////////
	// Datapath
	////////////////////

	always_ff @(posedge clock)
	begin
		if (in_valid && in_ready)
		begin
			// Dividend halved here, its low bit enters first
			rem <= {2'b00, dividend[R_W-1:1]};
			nbits <= {dividend[0], {(DIV_ITERS-1){1'b0}}};
			q <= '0;
			dvs <= divisor;
			neg <= negate;
		end
		else if (busy)
		begin
			nbits <= nbits << 1;
			// Restore by keeping trial when it is too small
			if (trial >= {1'b0, dvs})
			begin
				rem <= trial - {1'b0, dvs};
				q <= {q[OUT_W-2:0], 1'b1};
			end
			else
			begin
				rem <= trial;
				q <= {q[OUT_W-2:0], 1'b0};
			end
		end
	end

	// Fraction must stay below one
	a_proper_fraction: assert property (
		@(posedge clock) disable iff (!rst_n)
		(in_valid && in_ready) |-> (dividend < divisor)
	) else $error("[ERROR] divider dividend %h not below divisor %h", dividend, divisor);

endmodule

/* rtl/scratch_mem.sv */
`timescale 1ns/1ps

module scratch_mem
	import ld_fixed_pkg::*;
(
	input  logic              clock,
	input  logic              rst_n,
	input  logic [MEM_AW-1:0] addr,
	input  logic              wr_en,
	input  logic [R_W-1:0]    wr_data,
	output logic [R_W-1:0]    rd_data
);

	localparam int DEPTH = 1 << MEM_AW;

	// Four regions of sixteen words
	// r, two coefficient banks, rc
	logic [R_W-1:0] mem [DEPTH];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clock)
	begin
		if (wr_en)
		begin
			mem[addr] <= wr_data;
		end
	end

	////////////////////
	// Read port
	////////////////////

	// Old contents come back on a write cycle
	always_ff @(posedge clock)
	begin
		rd_data <= mem[addr];
	end

	// Write address must be known
	a_wr_addr_known: assert property (
		@(posedge clock) disable iff (!rst_n)
		wr_en |-> !$isunknown(addr)
	) else $error("[ERROR] scratch_mem write with unknown address %h", addr);

endmodule

/* rtl/ld_ctrl_pkg.sv */
package ld_ctrl_pkg;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SUM,
		CHECK,
		DIVIDE,
		UPDATE,
		NEXT,
		STREAM,
		FINISH
	} ld_state_e;

	// Multiplier opcodes
	// ACCUM with a zero operand leaves the accumulator as it is
	typedef enum logic [1:0] {
		CLEAR,
		ACCUM,
		PRODUCT
	} mac_op_e;

	// Upper address bits of the scratch memory
	typedef enum logic [1:0] {
		R_REGION,
		A_PING,
		A_PONG,
		RC_REGION
	} region_e;

endpackage

/* rtl/ld_fixed_pkg.sv */
package ld_fixed_pkg;

	////////////////////
	// Word widths
	////////////////////

	// Autocorrelation input word
	localparam int R_W = 32;
	// Working coefficient, Q27
	localparam int COEF_W = 32;
	// Multiplier accumulator
	localparam int ACC_W = 64;
	// Streamed coefficient, Q12 for a and Q15 for rc
	localparam int OUT_W = 16;

	////////////////////
	// Fraction bits
	////////////////////

	localparam int Q_A = 27;
	localparam int Q_K = 15;
	localparam int Q_OUT = 12;

	// Index into one memory region, ORDER up to 15
	localparam int IDX_W = 4;
	// Region plus index
	localparam int MEM_AW = 2 + IDX_W;
	// Shift amount port of the multiplier
	localparam int SHIFT_W = 6;
	// One quotient bit per divider cycle
	localparam int DIV_ITERS = Q_K + 1;

	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage
